// File: fetch_ctrl.sv
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                clk,
    input  logic                reset,
    input  logic                bad_addr,
    input  logic                addr_ok,
    input  logic                stall_d,
    input  fetch_pkg::redirect_t exc_redirect,
    input  fetch_pkg::redirect_t br_redirect,
    output logic                req_valid,
    output fetch_pkg::pc_src_t  pc_src,
    output logic                pc_en,
    output logic                save_en,
    output fetch_pkg::pc_src_t  save_src,
    output logic                f1_en,
    output logic                f1_flush,
    output logic                out_en,
    output logic                out_flush,
    output logic                f1_capture_valid
);

    typedef enum logic [1:0] {
        RUN,
        PEND_BR,
        PEND_EXC
    } state_t;

    state_t             state;
    state_t             state_next;
    logic               waiting;
    logic               step;
    logic               take_exc;
    logic               take_br;
    logic               take;
    fetch_pkg::pc_src_t new_src;

    // no request in reset, for a misaligned pc or while decode holds
    assign req_valid = ~reset & ~bad_addr & ~stall_d;
    // bus owes us an accept so the address must not move
    assign waiting = req_valid & ~addr_ok;
    // current pc is done when accepted or skipped as misaligned
    assign step = ~stall_d & (bad_addr | addr_ok);

    // exception first and a branch is dropped while an exception is parked
    assign take_exc = exc_redirect.valid;
    assign take_br = br_redirect.valid & ~exc_redirect.valid & (state != PEND_EXC);
    assign take = take_exc | take_br;
    assign new_src = take_exc ? fetch_pkg::EXC : fetch_pkg::BR;

    always_comb begin
        state_next = state;
        pc_en = 1'b0;
        pc_src = fetch_pkg::SEQ;
        save_en = 1'b0;
        save_src = new_src;
        f1_capture_valid = step;
        if (state == RUN) begin
            if (take && waiting) begin
                // park target until the old request goes out
                save_en = 1'b1;
                state_next = take_exc ? PEND_EXC : PEND_BR;
            end else if (take) begin
                pc_en = 1'b1;
                pc_src = new_src;
            end else begin
                pc_en = step;
            end
        end else begin
            // whatever leaves the bus now is on the wrong path
            f1_capture_valid = 1'b0;
            if (waiting) begin
                save_en = take;
                if (take_exc) begin
                    state_next = PEND_EXC;
                end
            end else begin
                // old request accepted or withdrawn so jump now
                pc_en = 1'b1;
                pc_src = take ? new_src : fetch_pkg::SAVED;
                state_next = RUN;
            end
        end
    end

    // both regs freeze on stall while flush still wins inside pipe_reg
    assign f1_en = ~stall_d;
    assign out_en = ~stall_d;
    assign f1_flush = take;
    assign out_flush = take;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= RUN;
        end else begin
            state <= state_next;
        end
    end

endmodule

// File: fetch_pkg.sv
package fetch_pkg;

    // basic widths
    typedef logic [31:0] word_t;
    typedef logic [63:0] dword_t;

    // pc step per fetch pair, and offset of the younger slot
    localparam word_t PAIR_BYTES = 32'd8;
    localparam word_t SLOT_BYTES = 32'd4;

    // next-pc select
    typedef enum logic [1:0] {
        SEQ,
        EXC,
        BR,
        SAVED
    } pc_src_t;

    // fetch-1 stage payload
    typedef struct packed {
        logic  valid;
        word_t pc;
        // misaligned pc, no bus request made
        logic  bad_addr;
    } f1_entry_t;

    // one instruction slot handed to decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t raw_instr;
        logic  bad_addr;
    } fetch_slot_t;

    // [1] is the older slot at pc, [0] sits at pc+4
    typedef fetch_slot_t [1:0] fetch_pair_t;

    // instruction bus
    typedef struct packed {
        logic  valid;
        word_t addr;
    } ibus_req_t;

    typedef struct packed {
        logic   addr_ok;
        // two instructions, low word at the lower address
        dword_t data;
    } ibus_resp_t;

    // one-cycle redirect pulse
    typedef struct packed {
        logic  valid;
        word_t target;
    } redirect_t;

endpackage

// File: fetch_sva.sv
`timescale 1ns/1ps

module fetch_sva (
    input logic                   clk,
    input logic                   reset,
    input fetch_pkg::ibus_req_t   ireq,
    input fetch_pkg::ibus_resp_t  iresp,
    input fetch_pkg::fetch_pair_t pair
);

    // a waiting request keeps its address until the bus takes it
    property addr_stable_p;
        @(posedge clk) disable iff (reset)
            (ireq.valid && !iresp.addr_ok) |=> $stable(ireq.addr);
    endproperty

    // misaligned pc never reaches the bus
    property no_bad_req_p;
        @(posedge clk) disable iff (reset)
            (ireq.addr[1:0] != 2'b00) |-> !ireq.valid;
    endproperty

    // both slots empty once reset has been seen
    property pair_clear_p;
        @(posedge clk) reset |=> (!pair[1].valid && !pair[0].valid);
    endproperty

    addr_stable_a: assert property (addr_stable_p)
        else $error("instruction bus address moved while waiting for addr_ok");
    no_bad_req_a: assert property (no_bad_req_p)
        else $error("bus request issued for a misaligned pc");
    pair_clear_a: assert property (pair_clear_p)
        else $error("fetch pair holds a valid slot after reset");

endmodule

// File: fetch_testdata.txt
# C cycles addr_ok stall_d exc_valid exc_target br_valid br_target tag
# E tag first_slot_pc slot_count bad_addr, slot pcs step by 4 in delivery order
C 4 1 0 0 00000000 0 00000000 sequential
C 3 0 0 0 00000000 0 00000000 bus_wait
C 3 1 0 0 00000000 0 00000000 bus_wait
C 1 1 0 0 00000000 0 00000000 stall_hold
C 3 1 1 0 00000000 0 00000000 stall_hold
C 2 1 0 0 00000000 0 00000000 stall_hold
C 1 1 0 1 bfc00380 1 bfc01000 redirect_priority
C 2 1 0 0 00000000 0 00000000 redirect_priority
C 1 0 0 1 bfc00400 0 00000000 redirect_priority
C 1 0 0 0 00000000 1 bfc02000 redirect_priority
C 4 1 0 0 00000000 0 00000000 redirect_priority
C 1 0 0 0 00000000 0 00000000 pending_discard
C 1 0 0 0 00000000 1 bfc03000 pending_discard
C 1 0 0 0 00000000 0 00000000 pending_discard
C 3 1 0 0 00000000 0 00000000 pending_discard
C 2 0 0 0 00000000 0 00000000 misaligned
C 1 1 0 0 00000000 1 bfc04002 misaligned
C 2 0 0 0 00000000 0 00000000 misaligned
C 1 0 0 0 00000000 1 bfc05000 misaligned
C 1 1 0 0 00000000 0 00000000 misaligned
C 3 0 0 0 00000000 0 00000000 misaligned
E sequential bfc00000 8 0
E bus_wait bfc00020 6 0
E stall_hold bfc00038 4 0
E redirect_priority bfc00380 2 0
E redirect_priority bfc00400 6 0
E pending_discard bfc03000 4 0
E misaligned bfc04002 1 1
E misaligned bfc05000 2 0

// File: fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter fetch_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic                   clk,
    input  logic                   reset,
    output fetch_pkg::ibus_req_t   ireq,
    input  fetch_pkg::ibus_resp_t  iresp,
    input  logic                   stall_d,
    input  fetch_pkg::redirect_t   exc_redirect,
    input  fetch_pkg::redirect_t   br_redirect,
    output fetch_pkg::fetch_pair_t pair
);

    fetch_pkg::word_t       pc;
    logic                   bad_addr;
    logic                   req_valid;
    fetch_pkg::pc_src_t     pc_src;
    logic                   pc_en;
    logic                   save_en;
    fetch_pkg::pc_src_t     save_src;
    logic                   f1_en;
    logic                   f1_flush;
    logic                   out_en;
    logic                   out_flush;
    logic                   f1_capture_valid;
    fetch_pkg::f1_entry_t   f1_d;
    fetch_pkg::f1_entry_t   f1_q;
    fetch_pkg::fetch_pair_t pair_d;

    // word alignment check on the fetch pc
    assign bad_addr = pc[1:0] != 2'b00;

    assign ireq.valid = req_valid;
    assign ireq.addr = pc;

    // entry for the pc leaving this cycle
    assign f1_d.valid = f1_capture_valid;
    assign f1_d.pc = pc;
    assign f1_d.bad_addr = bad_addr;

    fetch_ctrl u_ctrl (
        .clk, .reset, .bad_addr, .addr_ok(iresp.addr_ok), .stall_d,
        .exc_redirect, .br_redirect, .req_valid, .pc_src, .pc_en,
        .save_en, .save_src, .f1_en, .f1_flush, .out_en, .out_flush,
        .f1_capture_valid
    );

    pc_gen #(.reset_pc(reset_pc)) u_pc (
        .clk, .reset, .pc_en, .pc_src, .save_en, .save_src,
        .exc_target(exc_redirect.target), .br_target(br_redirect.target), .pc
    );

    // request in flight, data due next cycle
    pipe_reg #(.T(fetch_pkg::f1_entry_t)) f1_reg (
        .clk, .reset, .en(f1_en), .flush(f1_flush), .d(f1_d), .q(f1_q)
    );

    instr_buffer u_buf (
        .clk, .reset, .f1(f1_q), .data(iresp.data), .stall_d,
        .flush(f1_flush), .pair(pair_d)
    );

    // fetch/decode register
    pipe_reg #(.T(fetch_pkg::fetch_pair_t)) out_reg (
        .clk, .reset, .en(out_en), .flush(out_flush), .d(pair_d), .q(pair)
    );

endmodule

// File: filelist.f
fetch_pkg.sv
pipe_reg.sv
pc_gen.sv
fetch_ctrl.sv
instr_buffer.sv
fetch_top.sv
fetch_sva.sv
tb_fetch.sv

// File: instr_buffer.sv
`timescale 1ns/1ps

module instr_buffer (
    input  logic                   clk,
    input  logic                   reset,
    input  fetch_pkg::f1_entry_t   f1,
    input  fetch_pkg::dword_t      data,
    input  logic                   stall_d,
    input  logic                   flush,
    output fetch_pkg::fetch_pair_t pair
);

    fetch_pkg::dword_t saved_data;
    logic              saved_valid;
    fetch_pkg::dword_t raw;

    // bus data shows for one cycle only and is kept while decode holds
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            saved_valid <= 1'b0;
        end else if (stall_d && f1.valid && !saved_valid) begin
            saved_valid <= 1'b1;
        end else if (!stall_d) begin
            saved_valid <= 1'b0;
        end
    end

    // copy of the bus return from the first stalled cycle
    always_ff @(posedge clk) begin
        if (stall_d && f1.valid && !saved_valid) begin
            saved_data <= data;
        end
    end

    assign raw = saved_valid ? saved_data : data;

    always_comb begin
        // older slot, low word
        pair[1].valid = f1.valid;
        pair[1].pc = f1.pc;
        pair[1].raw_instr = raw[31:0];
        pair[1].bad_addr = f1.bad_addr;
        // younger slot, high word
        pair[0].valid = f1.valid & ~f1.bad_addr;
        pair[0].pc = f1.pc + fetch_pkg::SLOT_BYTES;
        pair[0].raw_instr = raw[63:32];
        pair[0].bad_addr = 1'b0;
        // nothing was fetched for a bad pc
        if (f1.bad_addr) begin
            pair[1].raw_instr = '0;
        end
    end

endmodule

// File: pc_gen.sv
`timescale 1ns/1ps

module pc_gen #(
    parameter fetch_pkg::word_t reset_pc = 32'hbfc0_0000
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              pc_en,
    input  fetch_pkg::pc_src_t pc_src,
    input  logic              save_en,
    input  fetch_pkg::pc_src_t save_src,
    input  fetch_pkg::word_t  exc_target,
    input  fetch_pkg::word_t  br_target,
    output fetch_pkg::word_t  pc
);

    fetch_pkg::word_t saved_target;
    fetch_pkg::word_t pc_next;

    // redirect target parked while the bus still owes an accept
    always_ff @(posedge clk) begin
        if (save_en) begin
            saved_target <= (save_src == fetch_pkg::EXC) ? exc_target : br_target;
        end
    end

    // next pc mux
    always_comb begin
        case (pc_src)
            fetch_pkg::EXC: begin
                pc_next = exc_target;
            end
            fetch_pkg::BR: begin
                pc_next = br_target;
            end
            fetch_pkg::SAVED: begin
                pc_next = saved_target;
            end
            default: begin
                // sequential, one pair further
                pc_next = pc + fetch_pkg::PAIR_BYTES;
            end
        endcase
    end

    // pc only moves when ctrl says so
    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= reset_pc;
        end else if (pc_en) begin
            pc <= pc_next;
        end
    end

endmodule

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  logic en,
    input  logic flush,
    input  T     d,
    output T     q
);

    // flush beats enable, clears the whole payload incl. valid bits
    always_ff @(posedge clk) begin
        if (reset || flush) begin
            q <= '0;
        end else if (en) begin
            q <= d;
        end
    end

endmodule

// File: tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

    localparam int RESET_CYCLES = 10;
    // bus model returns each word as its address xor this key
    localparam fetch_pkg::word_t INSTR_KEY = 32'h5a5a_0000;

    // one cycle of stimulus
    typedef struct packed {
        logic                 addr_ok;
        logic                 stall;
        fetch_pkg::redirect_t exc;
        fetch_pkg::redirect_t br;
    } stim_t;

    logic                   clk;
    logic                   reset;
    logic                   bus_addr_ok;
    fetch_pkg::dword_t      bus_data;
    logic                   stall_d;
    fetch_pkg::redirect_t   exc_redirect;
    fetch_pkg::redirect_t   br_redirect;
    fetch_pkg::ibus_req_t   ireq;
    fetch_pkg::ibus_resp_t  iresp;
    fetch_pkg::fetch_pair_t pair;
    fetch_pkg::fetch_pair_t last_pair;

    // stimulus and expected slots from the data file
    stim_t            stim_q[$];
    string            stim_tag_q[$];
    fetch_pkg::word_t exp_pc_q[$];
    logic             exp_bad_q[$];
    string            exp_tag_q[$];
    string            cur_tag;
    int               limit;
    int               cycle_count;
    int               error_count;
    int               test_errors;
    int               tests_passed;
    int               tests_failed;
    logic             held;
    logic             was_waiting;
    fetch_pkg::word_t waited_addr;
    integer           seed;

    assign iresp.addr_ok = bus_addr_ok;
    assign iresp.data = bus_data;

    fetch_top DUT (
        .clk, .reset, .ireq, .iresp, .stall_d, .exc_redirect, .br_redirect, .pair
    );

    bind fetch_top fetch_sva u_sva (.clk, .reset, .ireq, .iresp, .pair);

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic close_test(input string tag);
        if (test_errors == 0) begin
            $display("test %s: passed", tag);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", tag, test_errors);
            tests_failed++;
        end
        test_errors = 0;
    endtask

    task automatic check_slot(input fetch_pkg::fetch_slot_t s);
        fetch_pkg::word_t exp_pc;
        fetch_pkg::word_t exp_instr;
        logic             exp_bad;
        string            tag;
        if (exp_pc_q.size() == 0) begin
            $display("slot at pc %h delivered after the last expected slot", s.pc);
            error_count++;
            return;
        end
        exp_pc = exp_pc_q.pop_front();
        exp_bad = exp_bad_q.pop_front();
        tag = exp_tag_q.pop_front();
        // nothing is fetched for a misaligned pc
        exp_instr = exp_bad ? '0 : (exp_pc ^ INSTR_KEY);
        if (s.pc !== exp_pc) begin
            $display("ERROR %s: pc expected %h actual %h", tag, exp_pc, s.pc);
            test_errors++;
        end
        if (s.raw_instr !== exp_instr) begin
            $display("ERROR %s: instr expected %h actual %h", tag, exp_instr, s.raw_instr);
            test_errors++;
        end
        if (s.bad_addr !== exp_bad) begin
            $display("ERROR %s: bad_addr expected %b actual %b", tag, exp_bad, s.bad_addr);
            test_errors++;
        end
        // last slot of this tag closes the test
        if (exp_tag_q.size() == 0 || exp_tag_q[0] != tag) begin
            close_test(tag);
        end
    endtask

    task automatic load_testdata();
        int               fd;
        int               n;
        int               count;
        int               addr_ok;
        int               stall;
        int               exc_v;
        int               br_v;
        int               bad;
        fetch_pkg::word_t exc_tgt;
        fetch_pkg::word_t br_tgt;
        fetch_pkg::word_t first;
        string            line;
        string            tag;
        stim_t            s;
        fd = $fopen("fetch_testdata.txt", "r");
        if (fd == 0) begin
            $display("cannot open fetch_testdata.txt for reading");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.getc(0) == "C") begin
                n = $sscanf(line, "C %d %d %d %d %h %d %h %s",
                            count, addr_ok, stall, exc_v, exc_tgt, br_v, br_tgt, tag);
                if (n != 8) begin
                    $display("malformed cycle record in testdata: %s", line);
                    error_count++;
                end else begin
                    s.addr_ok = addr_ok[0];
                    s.stall = stall[0];
                    s.exc = '{valid: exc_v[0], target: exc_tgt};
                    s.br = '{valid: br_v[0], target: br_tgt};
                    // a record stands for count identical cycles
                    for (int i = 0; i < count; i++) begin
                        stim_q.push_back(s);
                        stim_tag_q.push_back(tag);
                    end
                end
            end else if (line.getc(0) == "E") begin
                n = $sscanf(line, "E %s %h %d %d", tag, first, count, bad);
                if (n != 4) begin
                    $display("malformed expected record in testdata: %s", line);
                    error_count++;
                end else begin
                    // slots step by one word in delivery order
                    for (int i = 0; i < count; i++) begin
                        exp_pc_q.push_back(first + i * fetch_pkg::SLOT_BYTES);
                        exp_bad_q.push_back(bad[0]);
                        exp_tag_q.push_back(tag);
                    end
                end
            end
        end
        $fclose(fd);
        if (stim_q.size() == 0 || exp_pc_q.size() == 0) begin
            $display("testdata holds no cycle records or no expected slots");
            error_count++;
        end
    endtask

    // bus model plus protocol checks on the request side
    always @(posedge clk) begin
        // data is only good in the cycle right after the accept
        if (ireq.valid && iresp.addr_ok) begin
            bus_data <= {(ireq.addr + fetch_pkg::SLOT_BYTES) ^ INSTR_KEY, ireq.addr ^ INSTR_KEY};
        end else begin
            bus_data <= {$random(seed), $random(seed)};
        end
        if (reset && ireq.valid) begin
            $display("bus request made while reset is asserted");
            error_count++;
        end
        if (!reset && ireq.valid && ireq.addr[1:0] != 2'b00) begin
            $display("bus request made for misaligned pc %h", ireq.addr);
            error_count++;
        end
        if (was_waiting && ireq.addr !== waited_addr) begin
            $display("bus address moved from %h to %h before addr_ok", waited_addr, ireq.addr);
            error_count++;
        end
        was_waiting = !reset && ireq.valid && !iresp.addr_ok;
        waited_addr = ireq.addr;
    end

    // pair settles after the edge so sample mid-cycle
    always @(negedge clk) begin
        if (!reset) begin
            if (!held) begin
                if (pair[1].valid) begin
                    check_slot(pair[1]);
                end
                if (pair[0].valid) begin
                    check_slot(pair[0]);
                end
            end else if (pair !== last_pair) begin
                $display("pair at pc %h changed while decode held it", last_pair[1].pc);
                error_count++;
            end
            last_pair = pair;
        end
        // out_reg holds across the next edge unless a redirect clears it
        held = stall_d && !exc_redirect.valid && !br_redirect.valid;
    end

    initial begin
        stim_t s;
        seed = 32'hd5c19f4d;
        reset = 1'b1;
        bus_addr_ok = 1'b0;
        bus_data = '0;
        stall_d = 1'b0;
        exc_redirect = '0;
        br_redirect = '0;
        last_pair = '0;
        held = 1'b0;
        was_waiting = 1'b0;
        waited_addr = '0;
        error_count = 0;
        test_errors = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count = 0;
        cur_tag = "reset";
        load_testdata();
        limit = stim_q.size() + RESET_CYCLES + 50;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (stim_q.size() > 0) begin
            s = stim_q.pop_front();
            cur_tag = stim_tag_q.pop_front();
            bus_addr_ok <= s.addr_ok;
            stall_d <= s.stall;
            exc_redirect <= s.exc;
            br_redirect <= s.br;
            @(posedge clk);
        end
        bus_addr_ok <= 1'b0;
        stall_d <= 1'b0;
        exc_redirect <= '0;
        br_redirect <= '0;
        // wait for the remaining expected slots
        while (exp_pc_q.size() > 0) @(posedge clk);
        // extra cycles catch slots delivered past the end
        repeat (4) @(posedge clk);
        $display("%0d tests passed, %0d failed, %0d other errors",
                 tests_passed, tests_failed, error_count);
        if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // cycle watchdog with its limit taken from the record count
    initial begin
        @(posedge clk);
        while (cycle_count < limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout after %0d cycles while running %s, %0d expected slots never arrived",
                 limit, cur_tag, exp_pc_q.size());
        $display("STATUS: FAIL");
        $finish;
    end

endmodule
